// ==== logic/merge_pkg.sv ====
// Packet, configuration and control state types shared by the merge data generator
`default_nettype none

package merge_pkg;

    // --------------------
    // Packet geometry
    // --------------------
    parameter int num_fields = 4;
    parameter int field_w    = 32;
    parameter int meta_w     = 16;

    // Mask vectors are sized to this upper bound on lanes
    parameter int max_lanes = 4;

    // --------------------
    // Engine packet
    // --------------------
    typedef struct packed {
        logic [meta_w-1:0]                  meta;
        logic [num_fields-1:0][field_w-1:0] field;
    } packet_payload_t;

    typedef struct packed {
        logic            valid;
        packet_payload_t payload;
    } engine_packet_t;

    // --------------------
    // Configuration
    // --------------------
    // Bit j set means lane j feeds field j
    typedef struct packed {
        logic                 valid;
        logic [max_lanes-1:0] mask;
    } merge_config_t;

    // --------------------
    // Control states
    // --------------------
    typedef enum logic [2:0] {
        merge_reset        = 3'd0,
        merge_idle         = 3'd1,
        merge_setup_wait   = 3'd2,
        merge_setup_trans  = 3'd3,
        merge_setup_config = 3'd4,
        merge_start        = 3'd5,
        merge_run          = 3'd6
    } merge_state_t;

endpackage

`default_nettype wire

// ==== logic/lane_fifo.sv ====
// Synchronous circular buffer FIFO with prog_full and an optional first-word-fall-through read
`default_nettype none

module lane_fifo #(
    parameter int data_w      = 8,
    parameter int depth       = 16,
    parameter int prog_thresh = 8,
    parameter bit fwft        = 1'b0
) (
    input  logic              ap_clk,
    input  logic              areset_generator,
    input  logic [data_w-1:0] din,
    input  logic              wr_en,
    input  logic              rd_en,
    output logic [data_w-1:0] dout,
    output logic              valid,
    output logic              empty,
    output logic              full,
    output logic              prog_full
);

    localparam int addr_w  = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_w = $clog2(depth + 1);

    logic [data_w-1:0]  mem [depth];
    logic [addr_w-1:0]  wr_ptr;
    logic [addr_w-1:0]  rd_ptr;
    logic [count_w-1:0] count;
    logic               push;
    logic               pop;

    // Requests beyond the limits are dropped
    assign push = wr_en & ~full;
    assign pop  = rd_en & ~empty;

    assign empty     = (count == '0);
    assign full      = (count == count_w'(depth));
    assign prog_full = (count >= count_w'(prog_thresh));

    // --------------------
    // Pointers and occupancy
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == addr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == addr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    // --------------------
    // Read port
    // --------------------
    generate
        if (fwft) begin : g_fwft
            // Head entry is always visible
            assign dout  = mem[rd_ptr];
            assign valid = ~empty;
        end else begin : g_std
            logic [data_w-1:0] dout_q;
            logic              valid_q;

            always_ff @(posedge ap_clk) begin
                if (pop) begin
                    dout_q <= mem[rd_ptr];
                end
                if (areset_generator) begin
                    valid_q <= 1'b0;
                end else begin
                    valid_q <= pop;
                end
            end

            assign dout  = dout_q;
            assign valid = valid_q;
        end
    endgenerate

endmodule

`default_nettype wire

// ==== logic/merge_config_decode.sv ====
// Control FSM for start, configuration request and merge mask latch
`default_nettype none

module merge_config_decode #(
    parameter int num_lanes = 4
) (
    input  logic                     ap_clk,
    input  logic                     areset_generator,
    input  logic                     start,
    input  logic                     config_enable,
    input  merge_pkg::merge_config_t config_in,
    output logic                     config_setup,
    output logic [num_lanes-1:0]     mask,
    output logic                     mask_valid,
    output logic                     configured
);

    merge_pkg::merge_state_t current_state;
    merge_pkg::merge_state_t next_state;
    logic [num_lanes-1:0]    mask_next;

    // --------------------
    // State register
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            current_state <= merge_pkg::merge_reset;
        end else begin
            current_state <= next_state;
        end
    end

    always_comb begin
        next_state = current_state;
        case (current_state)
            merge_pkg::merge_reset: begin
                next_state = merge_pkg::merge_idle;
            end
            merge_pkg::merge_idle: begin
                if (start) begin
                    next_state = merge_pkg::merge_setup_wait;
                end
            end
            merge_pkg::merge_setup_wait: begin
                // Config source ready
                if (config_enable) begin
                    next_state = merge_pkg::merge_setup_trans;
                end
            end
            merge_pkg::merge_setup_trans: begin
                next_state = merge_pkg::merge_setup_config;
            end
            merge_pkg::merge_setup_config: begin
                if (config_in.valid) begin
                    next_state = merge_pkg::merge_start;
                end
            end
            merge_pkg::merge_start: begin
                next_state = merge_pkg::merge_run;
            end
            merge_pkg::merge_run: begin
                // One job per reset
                next_state = merge_pkg::merge_run;
            end
            default: begin
                next_state = merge_pkg::merge_reset;
            end
        endcase
    end

    // --------------------
    // Outputs
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            config_setup <= 1'b0;
            mask_valid   <= 1'b0;
        end else begin
            config_setup <= (current_state == merge_pkg::merge_setup_trans);
            mask_valid   <= (current_state == merge_pkg::merge_start) ||
                            (current_state == merge_pkg::merge_run);
        end
    end

    // Lane 0 carries the metadata and is always merged
    assign mask_next = config_in.mask[num_lanes-1:0] | num_lanes'(1);

    always_ff @(posedge ap_clk) begin
        if ((current_state == merge_pkg::merge_setup_config) && config_in.valid) begin
            mask <= mask_next;
        end
    end

    assign configured = (current_state == merge_pkg::merge_start) ||
                        (current_state == merge_pkg::merge_run);

    // Setup request is a single pulse per job
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        config_setup |=> !config_setup)
        else $error("config_setup held for more than one cycle");

    assert property (@(posedge ap_clk) disable iff (areset_generator)
        mask_valid |-> mask[0])
        else $error("mask valid without lane 0");

endmodule

`default_nettype wire

// ==== logic/merge_execute.sv ====
// Lane FIFOs, aligned pop across masked lanes and field merge register
`default_nettype none

module merge_execute #(
    parameter int num_lanes   = 4,
    parameter int fifo_depth  = 16,
    parameter int prog_thresh = 8
) (
    input  logic                      ap_clk,
    input  logic                      areset_generator,
    input  merge_pkg::engine_packet_t lane_in [num_lanes],
    input  logic [num_lanes-1:0]      lane_enable,
    input  logic [num_lanes-1:0]      mask,
    input  logic                      mask_valid,
    input  logic                      out_prog_full,
    output merge_pkg::engine_packet_t merged,
    output logic [num_lanes-1:0]      lane_prog_full,
    output logic                      lanes_empty
);

    merge_pkg::packet_payload_t lane_dout [num_lanes];
    merge_pkg::packet_payload_t merged_next;
    logic [num_lanes-1:0]       lane_rd_en;
    logic [num_lanes-1:0]       lane_valid;
    logic [num_lanes-1:0]       lane_empty;
    logic [num_lanes-1:0]       lane_full;
    logic [num_lanes-1:0]       lane_thresh;
    logic [num_lanes-1:0]       lane_ready;
    logic                       pop_all;

    // --------------------
    // Lane FIFOs
    // --------------------
    generate
        for (genvar i = 0; i < num_lanes; i++) begin : g_lane
            lane_fifo #(
                .data_w     ($bits(merge_pkg::packet_payload_t)),
                .depth      (fifo_depth),
                .prog_thresh(prog_thresh),
                .fwft       (1'b0)
            ) u_lane_fifo (
                .ap_clk          (ap_clk),
                .areset_generator(areset_generator),
                .din             (lane_in[i].payload),
                .wr_en           (lane_in[i].valid),
                .rd_en           (lane_rd_en[i]),
                .dout            (lane_dout[i]),
                .valid           (lane_valid[i]),
                .empty           (lane_empty[i]),
                .full            (lane_full[i]),
                .prog_full       (lane_thresh[i])
            );

            assert property (@(posedge ap_clk) disable iff (areset_generator)
                lane_in[i].valid |-> !lane_full[i])
                else $error("push into full lane %0d", i);
        end
    endgenerate

    // All masked lanes pop together or none does
    assign lane_ready = ~lane_empty & lane_enable;
    assign pop_all    = mask_valid & ~out_prog_full & (&(lane_ready | ~mask));
    assign lane_rd_en = pop_all ? mask : '0;

    // --------------------
    // Field merge
    // --------------------
    always_comb begin
        merged_next = lane_dout[0];
        for (int j = 1; j < num_lanes; j++) begin
            if (mask[j]) begin
                merged_next.field[j] = lane_dout[j].field[0];
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        merged.payload <= merged_next;
        if (areset_generator) begin
            merged.valid   <= 1'b0;
            lane_prog_full <= '0;
        end else begin
            merged.valid   <= lane_valid[0];
            lane_prog_full <= lane_thresh;
        end
    end

    // Lanes drained and nothing left in the read or merge stage
    assign lanes_empty = (&lane_empty) & ~(|lane_valid) & ~merged.valid;

    assert property (@(posedge ap_clk) disable iff (areset_generator)
        (|lane_rd_en) |-> lane_rd_en[0])
        else $error("masked lane popped without lane 0");

endmodule

`default_nettype wire

// ==== logic/merge_result.sv ====
// Output FIFO, downstream pop, output register and done tracking
`default_nettype none

module merge_result #(
    parameter int fifo_depth  = 16,
    parameter int prog_thresh = 8
) (
    input  logic                      ap_clk,
    input  logic                      areset_generator,
    input  merge_pkg::engine_packet_t merged,
    input  logic                      request_enable,
    input  logic                      lanes_empty,
    input  logic                      configured,
    output merge_pkg::engine_packet_t request_out,
    output logic                      out_prog_full,
    output logic                      request_prog_full,
    output logic                      done
);

    merge_pkg::packet_payload_t out_dout;
    logic                       out_rd_en;
    logic                       out_valid;
    logic                       out_empty;
    logic                       out_full;

    lane_fifo #(
        .data_w     ($bits(merge_pkg::packet_payload_t)),
        .depth      (fifo_depth),
        .prog_thresh(prog_thresh),
        .fwft       (1'b1)
    ) u_out_fifo (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .din             (merged.payload),
        .wr_en           (merged.valid),
        .rd_en           (out_rd_en),
        .dout            (out_dout),
        .valid           (out_valid),
        .empty           (out_empty),
        .full            (out_full),
        .prog_full       (out_prog_full)
    );

    // Drain while downstream allows
    assign out_rd_en = out_valid & request_enable;

    // --------------------
    // Output register
    // --------------------
    always_ff @(posedge ap_clk) begin
        request_out.payload <= out_dout;
        if (areset_generator) begin
            request_out.valid <= 1'b0;
            request_prog_full <= 1'b0;
            done              <= 1'b0;
        end else begin
            request_out.valid <= out_rd_en;
            request_prog_full <= out_prog_full;
            done              <= configured & lanes_empty & out_empty;
        end
    end

    // Execute stalls on prog_full well before the FIFO fills
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        merged.valid |-> !out_full)
        else $error("write into full output FIFO");

endmodule

`default_nettype wire

// ==== logic/merge_data_generator.sv ====
// Merge data generator top level with input registers, reset register and stage instances
`default_nettype none

module merge_data_generator #(
    parameter int num_lanes   = 4,
    parameter int fifo_depth  = 16,
    parameter int prog_thresh = 8
) (
    input  logic                      ap_clk,
    input  logic                      areset,
    input  logic                      start,
    input  logic                      config_enable,
    input  merge_pkg::merge_config_t  config_in,
    input  merge_pkg::engine_packet_t lane_in [num_lanes],
    input  logic [num_lanes-1:0]      lane_enable,
    input  logic                      request_enable,
    output merge_pkg::engine_packet_t request_out,
    output logic                      config_setup,
    output logic [num_lanes-1:0]      lane_prog_full,
    output logic                      request_prog_full,
    output logic                      done
);

    logic                      areset_generator;
    logic                      start_reg;
    logic                      config_enable_reg;
    logic                      request_enable_reg;
    logic [num_lanes-1:0]      lane_enable_reg;
    merge_pkg::merge_config_t  config_in_reg;
    merge_pkg::engine_packet_t lane_in_reg [num_lanes];

    logic [num_lanes-1:0]      mask;
    logic                      mask_valid;
    logic                      configured;
    merge_pkg::engine_packet_t merged;
    logic                      out_prog_full;
    logic                      lanes_empty;

    always_ff @(posedge ap_clk) begin
        areset_generator <= areset;
    end

    // --------------------
    // Input registers
    // --------------------
    always_ff @(posedge ap_clk) begin
        config_in_reg.mask <= config_in.mask;
        for (int i = 0; i < num_lanes; i++) begin
            lane_in_reg[i].payload <= lane_in[i].payload;
        end
        if (areset_generator) begin
            start_reg           <= 1'b0;
            config_enable_reg   <= 1'b0;
            request_enable_reg  <= 1'b0;
            lane_enable_reg     <= '0;
            config_in_reg.valid <= 1'b0;
            for (int i = 0; i < num_lanes; i++) begin
                lane_in_reg[i].valid <= 1'b0;
            end
        end else begin
            start_reg           <= start;
            config_enable_reg   <= config_enable;
            request_enable_reg  <= request_enable;
            lane_enable_reg     <= lane_enable;
            config_in_reg.valid <= config_in.valid;
            for (int i = 0; i < num_lanes; i++) begin
                lane_in_reg[i].valid <= lane_in[i].valid;
            end
        end
    end

    // --------------------
    // Stages
    // --------------------
    merge_config_decode #(
        .num_lanes(num_lanes)
    ) u_decode (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .start           (start_reg),
        .config_enable   (config_enable_reg),
        .config_in       (config_in_reg),
        .config_setup    (config_setup),
        .mask            (mask),
        .mask_valid      (mask_valid),
        .configured      (configured)
    );

    merge_execute #(
        .num_lanes  (num_lanes),
        .fifo_depth (fifo_depth),
        .prog_thresh(prog_thresh)
    ) u_execute (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .lane_in         (lane_in_reg),
        .lane_enable     (lane_enable_reg),
        .mask            (mask),
        .mask_valid      (mask_valid),
        .out_prog_full   (out_prog_full),
        .merged          (merged),
        .lane_prog_full  (lane_prog_full),
        .lanes_empty     (lanes_empty)
    );

    merge_result #(
        .fifo_depth (fifo_depth),
        .prog_thresh(prog_thresh)
    ) u_result (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .merged           (merged),
        .request_enable   (request_enable_reg),
        .lanes_empty      (lanes_empty),
        .configured       (configured),
        .request_out      (request_out),
        .out_prog_full    (out_prog_full),
        .request_prog_full(request_prog_full),
        .done             (done)
    );

endmodule

`default_nettype wire

// ==== bench/merge_clock_gen.sv ====
// Testbench clock and synchronous reset source
`default_nettype none

module merge_clock_gen #(
    parameter int reset_cycles = 4
) (
    input  logic reset_req,
    output logic ap_clk,
    output logic areset
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [3:0] reset_count = 4'(reset_cycles);

    // 100 ns period
    initial begin
        ap_clk = 1'b0;
        forever #50 ap_clk = ~ap_clk;
    end

    // Reset held for reset_cycles edges after each request
    always @(posedge ap_clk) begin
        if (reset_req) begin
            reset_count <= 4'(reset_cycles);
        end else if (reset_count != 4'd0) begin
            reset_count <= reset_count - 4'd1;
        end
    end

    assign areset = (reset_count != 4'd0);

endmodule

`default_nettype wire

// ==== bench/merge_tb.sv ====
// Testbench top with random lane stimulus, merge reference model, output checker and timeout
`default_nettype none

module merge_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_lanes    = 4;
    localparam int fifo_depth   = 16;
    localparam int prog_thresh  = 8;
    localparam int num_jobs     = 4;
    localparam int drain_cycles = 40;
    localparam int cmp_w        = 160;

    logic                      ap_clk;
    logic                      areset;
    logic                      reset_req;
    logic                      start;
    logic                      config_enable;
    merge_pkg::merge_config_t  config_in;
    merge_pkg::engine_packet_t lane_in [num_lanes];
    logic [num_lanes-1:0]      lane_enable;
    logic                      request_enable;
    merge_pkg::engine_packet_t request_out;
    logic                      config_setup;
    logic [num_lanes-1:0]      lane_prog_full;
    logic                      request_prog_full;
    logic                      done;

    // Model and bookkeeping
    logic [31:0]                rng_state = 32'h54a7e956;
    merge_pkg::packet_payload_t lane_model [num_lanes][$];
    int                         push_left [num_lanes];
    logic [num_lanes-1:0]       job_mask;
    int                         job_index;
    int                         out_count;
    int                         exp_total;
    int                         setup_count;
    logic                       setup_prev;
    logic                       config_sent;
    logic                       pushing;
    int                         sent_total = 0;
    int                         jobs_started = 0;
    int                         cycle_count = 0;

    merge_clock_gen #(
        .reset_cycles(4)
    ) u_clock_gen (
        .reset_req(reset_req),
        .ap_clk   (ap_clk),
        .areset   (areset)
    );

    merge_data_generator #(
        .num_lanes  (num_lanes),
        .fifo_depth (fifo_depth),
        .prog_thresh(prog_thresh)
    ) UUT (
        .ap_clk           (ap_clk),
        .areset           (areset),
        .start            (start),
        .config_enable    (config_enable),
        .config_in        (config_in),
        .lane_in          (lane_in),
        .lane_enable      (lane_enable),
        .request_enable   (request_enable),
        .request_out      (request_out),
        .config_setup     (config_setup),
        .lane_prog_full   (lane_prog_full),
        .request_prog_full(request_prog_full),
        .done             (done)
    );

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic stop_on_error();
        $display("Checks failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compare(input string name, input logic [cmp_w-1:0] expected,
                           input logic [cmp_w-1:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s expected %0h actual %0h", name, expected, actual);
            stop_on_error();
        end
    endtask

    function automatic int pushes_remaining();
        int total;
        total = 0;
        for (int i = 0; i < num_lanes; i++) begin
            total += push_left[i];
        end
        return total;
    endfunction

    function automatic logic model_empty();
        logic empty;
        empty = 1'b1;
        for (int i = 0; i < num_lanes; i++) begin
            if (lane_model[i].size() != 0) begin
                empty = 1'b0;
            end
        end
        return empty;
    endfunction

    // Cycle limit grows with the traffic sent
    always @(posedge ap_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > 20 * sent_total + 200 * jobs_started) begin
            $display("timeout: run did not finish within %0d cycles", cycle_count);
            stop_on_error();
        end
    end

    // --------------------
    // Per-cycle drive and check
    // --------------------
    task automatic drive_inputs();
        logic [31:0]                r;
        merge_pkg::packet_payload_t payload;
        for (int i = 0; i < num_lanes; i++) begin
            r = next_random();
            lane_in[i].valid = 1'b0;
            if (pushing && push_left[i] > 0 && !lane_prog_full[i] && r[1:0] != 2'b00) begin
                payload.meta = r[31:16];
                for (int f = 0; f < merge_pkg::num_fields; f++) begin
                    payload.field[f] = next_random();
                end
                lane_in[i].valid   = 1'b1;
                lane_in[i].payload = payload;
                lane_model[i].push_back(payload);
                push_left[i]--;
                sent_total++;
            end
        end
        r = next_random();
        // Enable pattern differs per job
        lane_enable = (job_index % 2 == 1) ? (r[num_lanes-1:0] | r[num_lanes+3:4]) : '1;
        if (job_index < 2) begin
            request_enable = 1'b1;
        end else if (job_index == 2) begin
            request_enable = (r[13:12] == 2'b00);
        end else begin
            request_enable = r[14];
        end
    endtask

    task automatic check_outputs();
        merge_pkg::packet_payload_t expected;
        merge_pkg::packet_payload_t head;
        if (config_setup && setup_prev) begin
            $display("config_setup stayed high for two cycles");
            stop_on_error();
        end
        setup_prev = config_setup;
        if (config_setup) begin
            setup_count++;
        end
        // A FIFO never holds more entries than the model still has pending
        for (int i = 0; i < num_lanes; i++) begin
            if (lane_model[i].size() < prog_thresh) begin
                compare($sformatf("lane_prog_full[%0d]", i), cmp_w'(1'b0),
                        cmp_w'(lane_prog_full[i]));
            end
        end
        if (lane_model[0].size() < prog_thresh) begin
            compare("request_prog_full", cmp_w'(1'b0), cmp_w'(request_prog_full));
        end
        if (request_out.valid) begin
            if (!config_sent) begin
                $display("output packet appeared before the configuration strobe");
                stop_on_error();
            end
            for (int i = 0; i < num_lanes; i++) begin
                if (job_mask[i] && lane_model[i].size() == 0) begin
                    $display("output packet with no pending input on lane %0d", i);
                    stop_on_error();
                end
            end
            // Lane 0 gives metadata and unmasked fields
            expected = lane_model[0].pop_front();
            for (int j = 1; j < num_lanes; j++) begin
                if (job_mask[j]) begin
                    head = lane_model[j].pop_front();
                    expected.field[j] = head.field[0];
                end
            end
            compare("request_out.payload", cmp_w'(expected), cmp_w'(request_out.payload));
            out_count++;
        end
    endtask

    task automatic step();
        drive_inputs();
        @(posedge ap_clk);
        #1;
        check_outputs();
    endtask

    task automatic apply_reset();
        start          = 1'b0;
        config_enable  = 1'b0;
        config_in      = '0;
        lane_enable    = '0;
        request_enable = 1'b0;
        for (int i = 0; i < num_lanes; i++) begin
            lane_in[i] = '0;
        end
        reset_req = 1'b1;
        @(posedge ap_clk);
        #1;
        reset_req = 1'b0;
        while (areset) begin
            @(posedge ap_clk);
            #1;
        end
        // Internal reset register lags by one cycle
        repeat (2) begin
            @(posedge ap_clk);
            #1;
        end
    endtask

    // --------------------
    // One job
    // --------------------
    task automatic run_job();
        logic [31:0]                   r;
        logic [merge_pkg::max_lanes-1:0] cfg_mask;
        logic                          exp_done;
        int                            base;
        jobs_started++;
        pushing     = 1'b0;
        config_sent = 1'b0;
        setup_count = 0;
        setup_prev  = 1'b0;
        out_count   = 0;
        job_mask    = '0;
        for (int i = 0; i < num_lanes; i++) begin
            lane_model[i].delete();
        end

        // Masked lanes differ by a few packets so no lane stalls on prog_full
        r         = next_random();
        cfg_mask  = r[merge_pkg::max_lanes-1:0];
        base      = 8 + int'(r[8:4]);
        exp_total = -1;
        for (int i = 0; i < num_lanes; i++) begin
            r = next_random();
            if (i == 0 || cfg_mask[i]) begin
                push_left[i] = base + ((job_index == num_jobs - 1) ? 0 : int'(r[1:0]));
                if (exp_total < 0 || push_left[i] < exp_total) begin
                    exp_total = push_left[i];
                end
            end else if (job_index == num_jobs - 1) begin
                push_left[i] = 0;
            end else begin
                push_left[i] = 1 + int'(r[4:2]) % (prog_thresh - 1);
            end
        end

        apply_reset();
        repeat (5) begin
            step();
            compare("request_out.valid", cmp_w'(1'b0), cmp_w'(request_out.valid));
            compare("config_setup", cmp_w'(1'b0), cmp_w'(config_setup));
            compare("done", cmp_w'(1'b0), cmp_w'(done));
        end

        // Start and the configuration handshake while lanes already fill
        start   = 1'b1;
        pushing = 1'b1;
        step();
        start         = 1'b0;
        config_enable = 1'b1;
        while (setup_count == 0) begin
            step();
        end
        repeat (3) step();
        compare("config_setup pulse count", cmp_w'(1), cmp_w'(setup_count));

        config_in.valid = 1'b1;
        config_in.mask  = cfg_mask;
        job_mask        = cfg_mask[num_lanes-1:0] | num_lanes'(1);
        config_sent     = 1'b1;
        step();
        config_in.valid = 1'b0;
        config_enable   = 1'b0;

        while (pushes_remaining() > 0) begin
            step();
        end
        repeat (4) step();
        while (out_count < exp_total) begin
            step();
            compare("done", cmp_w'(1'b0), cmp_w'(done));
        end

        // Nothing extra comes out and done follows what is left in the lanes
        repeat (drain_cycles) step();
        compare("output count", cmp_w'(exp_total), cmp_w'(out_count));
        exp_done = model_empty();
        repeat (10) begin
            step();
            compare("done", cmp_w'(exp_done), cmp_w'(done));
        end
    endtask

    initial begin
        reset_req      = 1'b0;
        start          = 1'b0;
        config_enable  = 1'b0;
        config_in      = '0;
        lane_enable    = '0;
        request_enable = 1'b0;
        for (int i = 0; i < num_lanes; i++) begin
            lane_in[i] = '0;
        end
        for (job_index = 0; job_index < num_jobs; job_index++) begin
            run_job();
        end
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
logic/merge_pkg.sv
logic/lane_fifo.sv
logic/merge_config_decode.sv
logic/merge_execute.sv
logic/merge_result.sv
logic/merge_data_generator.sv
bench/merge_clock_gen.sv
bench/merge_tb.sv

// ==== Makefile ====
# Verilator build and run for the merge data generator testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = merge_tb
FILELIST  = compile.f
BUILD_DIR = obj_dir

SIM     = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
